// File: list.f
logic/sms_pkg.sv
logic/download_if.sv
logic/ce_divider.sv
logic/cart_loader.sv
logic/cheat_code_loader.sv
logic/backup_sequencer.sv
logic/sms_cart_glue.sv
bench/tb_sms_cart_glue.sv

// File: Makefile
TOP = tb_sms_cart_glue

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

# The log decides the result, the exit status of the simulator does not
run: build
	./obj_dir/$(TOP) | tee run.log
	grep -q "^Simulation passed$$" run.log

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module sms_cart_glue

clean:
	rm -rf obj_dir run.log

// File: bench/tb_sms_cart_glue.sv
//============================================================
// Testbench for the cartridge glue with clock, ROM and SD
// models, reference functions, checks and watchdog
//============================================================

`timescale 1ns/100ps

module tb_sms_cart_glue import sms_pkg::*; ();

	localparam integer SEED        = 32'h1be6_7405;
	localparam int SECTOR_BITS     = 6;
	localparam int NUM_SECTORS     = 1 << SECTOR_BITS;
	localparam int CE_CYCLES       = 300;
	localparam int GG_BYTES        = 200;
	localparam int SMS_BYTES       = 16;
	localparam int CHEAT_BYTES     = 16;
	localparam int MASK_READS      = 20;
	localparam int ROM_MAX_DELAY   = 6;
	localparam int SD_MAX_DELAY    = 4;

	//============================================================
	// Watchdog budget from the worst case of each test
	//============================================================
	localparam int BYTE_MAX_CYCLES   = ROM_MAX_DELAY + 4;
	localparam int SECTOR_MAX_CYCLES = 2 * SD_MAX_DELAY + 4;
	localparam int TEST_CYCLES       = CE_CYCLES +
		(GG_BYTES + 2 * SMS_BYTES + CHEAT_BYTES) * BYTE_MAX_CYCLES +
		3 * NUM_SECTORS * SECTOR_MAX_CYCLES;
	localparam int WATCHDOG_CYCLES   = 8 * TEST_CYCLES;

	logic clk_sys = 1'b0;
	logic RESET;
	logic download, dl_wr, dl_wait;
	dl_addr_t dl_addr;
	byte_t dl_data, dl_index;
	logic rom_wr_req, rom_wr_ack;
	rom_addr_t rom_wr_addr, cpu_rom_addr, rom_rd_addr;
	byte_t rom_wr_data;
	logic is_gg, ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic [31:0] code_flags, code_addr, code_compare, code_replace;
	logic code_valid;
	logic img_mounted, img_readonly, img_size_nz, bk_load, bk_save;
	logic autosave, osd_open, nvram_we, sd_ack, sd_rd, sd_wr;
	logic [SECTOR_BITS-1:0] sd_lba;
	logic bk_busy, bk_pending, core_reset;

	integer seed = SEED;
	integer delay_seed = SEED + 1;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int valid_pulses = 0;

	// Host bytes sent and what the models observed
	byte_t sent_bytes[$];
	rom_addr_t rom_addrs[$];
	byte_t rom_datas[$];
	logic [SECTOR_BITS-1:0] sd_lbas[$];
	bit sd_writes[$];

	sms_cart_glue u_sms_cart_glue (.*);

	always #4 clk_sys = ~clk_sys;

	//============================================================
	// Reference functions
	//============================================================
	function automatic rom_addr_t expected_mask(input int n_bytes);
		rom_addr_t m;
		m = '0;
		// Address 0 restarts the mask, every other address is ORed in
		for (int a = 0; a < n_bytes; a++)
			m = (a == 0) ? '0 : (m | rom_addr_t'(a));
		return m;
	endfunction

	function automatic logic [31:0] expected_field(input int f);
		return {sent_bytes[4*f+3], sent_bytes[4*f+2], sent_bytes[4*f+1], sent_bytes[4*f]};
	endfunction

	function automatic logic [SECTOR_BITS-1:0] expected_lba(input int n);
		return SECTOR_BITS'(n % NUM_SECTORS);
	endfunction

	//============================================================
	// Check and report helpers
	//============================================================
	task automatic check_hex(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s got %0h expected %0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %-20s ok", name);
		end else begin
			tests_failed++;
			$display("test %-20s FAIL with %0d errors", name, errors - errs_before);
		end
	endtask

	// One image over the host port, next byte only after dl_wait drops
	task automatic send_image(input byte_t index, input int n_bytes);
		integer rnd;
		sent_bytes.delete();
		@(negedge clk_sys);
		dl_index = index;
		download = 1'b1;
		@(negedge clk_sys);
		for (int k = 0; k < n_bytes; k++) begin
			rnd = $random(seed);
			sent_bytes.push_back(rnd[7:0]);
			dl_addr = dl_addr_t'(k);
			dl_data = rnd[7:0];
			dl_wr = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			while (dl_wait)
				@(negedge clk_sys);
		end
		download = 1'b0;
	endtask

	task automatic wait_transfer();
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	task automatic check_sectors(input bit expect_write);
		check_hex("sector count", sd_lbas.size(), NUM_SECTORS);
		for (int i = 0; i < sd_lbas.size(); i++) begin
			check_hex("sd_lba", sd_lbas[i], expected_lba(i));
			check_hex("sd_wr", sd_writes[i], expect_write);
		end
		sd_lbas.delete();
		sd_writes.delete();
	endtask

	//============================================================
	// ROM memory model, toggles ack after 1 to 6 cycles
	//============================================================
	initial begin : rom_model
		logic req_seen;
		int delay;
		forever begin
			@(negedge clk_sys);
			if (rom_wr_req !== rom_wr_ack) begin
				req_seen = rom_wr_req;
				rom_addrs.push_back(rom_wr_addr);
				rom_datas.push_back(rom_wr_data);
				delay = 1 + ($unsigned($random(delay_seed)) % ROM_MAX_DELAY);
				repeat (delay) begin
					@(negedge clk_sys);
					assert (rom_wr_req === req_seen) else begin
						$display("second ROM write issued while one was outstanding");
						errors++;
					end
				end
				rom_wr_ack = req_seen;
			end
		end
	end

	// SD host model, raises and later drops sd_ack per sector
	initial begin : sd_model
		int delay;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				sd_lbas.push_back(sd_lba);
				sd_writes.push_back(sd_wr);
				delay = 1 + ($unsigned($random(delay_seed)) % SD_MAX_DELAY);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				@(negedge clk_sys);
				assert (!sd_rd && !sd_wr) else begin
					$display("sector request still high after sd_ack rose");
					errors++;
				end
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid === 1'b1)
			valid_pulses++;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, a handshake never completed",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	//============================================================
	// Test sequence
	//============================================================
	initial begin : stimulus
		int errs;
		int n_sp, n_vdp, n_pix, n_cpu;
		integer rnd;
		rom_addr_t mask;

		RESET = 1'b1;
		download = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_index = '0;
		rom_wr_ack = 1'b0;
		cpu_rom_addr = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_open = 1'b0;
		nvram_we = 1'b0;
		sd_ack = 1'b0;

		// Two clock cycles of reset
		errs = errors;
		repeat (2) begin
			@(negedge clk_sys);
			check_hex("enables in reset", {ce_cpu, ce_vdp, ce_pix, ce_sp}, 4'h0);
			check_hex("dl_wait", dl_wait, 1'b0);
			check_hex("sd_rd/sd_wr", {sd_rd, sd_wr}, 2'b00);
			check_hex("bk_busy/bk_pending", {bk_busy, bk_pending}, 2'b00);
		end
		RESET = 1'b0;
		report_test("reset state", errs);

		errs = errors;
		n_sp = 0;
		n_vdp = 0;
		n_pix = 0;
		n_cpu = 0;
		for (int i = 0; i < CE_CYCLES; i++) begin
			@(negedge clk_sys);
			n_sp += ce_sp;
			n_vdp += ce_vdp;
			n_pix += ce_pix;
			n_cpu += ce_cpu;
			check_hex("ce_cpu without ce_vdp", ce_cpu && !ce_vdp, 1'b0);
			check_hex("ce_pix without ce_vdp", ce_pix && !ce_vdp, 1'b0);
		end
		check_hex("ce_sp count", n_sp, CE_CYCLES / 2);
		check_hex("ce_vdp count", n_vdp, CE_CYCLES / 5);
		check_hex("ce_pix count", n_pix, CE_CYCLES / 10);
		check_hex("ce_cpu count", n_cpu, CE_CYCLES / 15);
		report_test("clock enables", errs);

		errs = errors;
		send_image(IDX_GG, GG_BYTES);
		repeat (2) @(negedge clk_sys);
		check_hex("rom write count", rom_addrs.size(), GG_BYTES);
		for (int k = 0; k < rom_addrs.size(); k++) begin
			check_hex("rom_wr_addr", rom_addrs[k], k);
			check_hex("rom_wr_data", rom_datas[k], sent_bytes[k]);
		end
		check_hex("is_gg", is_gg, 1'b1);
		report_test("gg download", errs);

		errs = errors;
		mask = expected_mask(GG_BYTES);
		for (int i = 0; i < MASK_READS; i++) begin
			rnd = $random(seed);
			cpu_rom_addr = rnd[21:0];
			@(negedge clk_sys);
			check_hex("rom_rd_addr", rom_rd_addr, cpu_rom_addr & mask);
		end
		report_test("rom read mask", errs);

		// Writable save image, so backup gets enabled by this download
		errs = errors;
		img_mounted = 1'b1;
		rom_addrs.delete();
		rom_datas.delete();
		send_image(IDX_SMS, SMS_BYTES);
		repeat (4) @(negedge clk_sys);
		check_hex("rom write count", rom_addrs.size(), SMS_BYTES);
		check_hex("is_gg", is_gg, 1'b0);
		check_hex("bk_busy", bk_busy, 1'b0);
		report_test("sms download", errs);

		errs = errors;
		rom_addrs.delete();
		send_image(IDX_CHEAT, CHEAT_BYTES);
		repeat (3) @(negedge clk_sys);
		check_hex("code_flags", code_flags, expected_field(0));
		check_hex("code_addr", code_addr, expected_field(1));
		check_hex("code_compare", code_compare, expected_field(2));
		check_hex("code_replace", code_replace, expected_field(3));
		check_hex("code_valid pulses", valid_pulses, 1);
		check_hex("rom write count", rom_addrs.size(), 0);
		report_test("cheat code", errs);

		errs = errors;
		@(negedge clk_sys);
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_transfer();
		check_sectors(1'b1);
		report_test("backup save", errs);

		errs = errors;
		nvram_we = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		@(negedge clk_sys);
		check_hex("bk_pending", bk_pending, 1'b1);
		autosave = 1'b1;
		osd_open = 1'b1;
		wait_transfer();
		check_hex("bk_pending", bk_pending, 1'b0);
		check_sectors(1'b1);
		autosave = 1'b0;
		osd_open = 1'b0;
		report_test("autosave", errs);

		// Download end with a non-empty save image loads it
		errs = errors;
		img_size_nz = 1'b1;
		send_image(IDX_SMS, SMS_BYTES);
		@(negedge clk_sys);
		check_hex("bk_busy", bk_busy, 1'b1);
		while (bk_busy) begin
			check_hex("core_reset", core_reset, 1'b1);
			@(negedge clk_sys);
		end
		check_hex("core_reset", core_reset, 1'b0);
		check_sectors(1'b0);
		report_test("load after download", errs);

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: logic/sms_cart_glue.sv
//============================================================
// Cartridge-side glue top level with clock enables,
// ROM download, cheat codes and backup RAM transfer
//============================================================

`timescale 1ns/100ps

module sms_cart_glue import sms_pkg::*; #(
	parameter int BK_SECTOR_BITS = 6,
	parameter int ROM_ADDR_W     = 22
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	// Host download
	input  logic                      download,
	input  logic                      dl_wr,
	input  dl_addr_t                  dl_addr,
	input  byte_t                     dl_data,
	input  byte_t                     dl_index,
	output logic                      dl_wait,
	// ROM memory
	output logic                      rom_wr_req,
	input  logic                      rom_wr_ack,
	output rom_addr_t                 rom_wr_addr,
	output byte_t                     rom_wr_data,
	input  rom_addr_t                 cpu_rom_addr,
	output rom_addr_t                 rom_rd_addr,
	output logic                      is_gg,
	// Clock enables
	output logic                      ce_cpu,
	output logic                      ce_vdp,
	output logic                      ce_pix,
	output logic                      ce_sp,
	// Cheat code
	output logic [31:0]               code_flags,
	output logic [31:0]               code_addr,
	output logic [31:0]               code_compare,
	output logic [31:0]               code_replace,
	output logic                      code_valid,
	// Backup RAM and save image
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic                      img_size_nz,
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      autosave,
	input  logic                      osd_open,
	input  logic                      nvram_we,
	input  logic                      sd_ack,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [BK_SECTOR_BITS-1:0] sd_lba,
	output logic                      bk_busy,
	output logic                      bk_pending,
	output logic                      core_reset
);

	logic        cart_active;
	cheat_code_u code;

	download_if u_dl (.clk_sys(clk_sys));

	assign u_dl.download = download;
	assign u_dl.wr       = dl_wr;
	assign u_dl.addr     = dl_addr;
	assign u_dl.data     = dl_data;
	assign u_dl.index    = dl_index;

	ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader #(.ROM_ADDR_W(ROM_ADDR_W)) u_cart_loader (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (u_dl),
		.rom_wr_ack   (rom_wr_ack),
		.cpu_rom_addr (cpu_rom_addr),
		.dl_wait      (dl_wait),
		.rom_wr_req   (rom_wr_req),
		.rom_wr_addr  (rom_wr_addr),
		.rom_wr_data  (rom_wr_data),
		.cart_active  (cart_active),
		.is_gg        (is_gg),
		.rom_rd_addr  (rom_rd_addr)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (u_dl),
		.code       (code),
		.code_valid (code_valid)
	);

	// Cheat engine reads the field view
	assign code_flags   = code.fields.flags;
	assign code_addr    = code.fields.address;
	assign code_compare = code.fields.compare;
	assign code_replace = code.fields.replace;

	backup_sequencer #(.BK_SECTOR_BITS(BK_SECTOR_BITS)) u_backup_sequencer (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_active  (cart_active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.nvram_we     (nvram_we),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.core_reset   (core_reset)
	);

endmodule

// File: logic/backup_sequencer.sv
//============================================================
// Backup RAM enable and pending flag, sector transfer FSM
// and core reset
//============================================================

`timescale 1ns/100ps

module backup_sequencer #(
	parameter int BK_SECTOR_BITS = 6
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      cart_active,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic                      img_size_nz,
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      autosave,
	input  logic                      osd_open,
	input  logic                      nvram_we,
	input  logic                      sd_ack,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [BK_SECTOR_BITS-1:0] sd_lba,
	output logic                      bk_busy,
	output logic                      bk_pending,
	output logic                      core_reset
);

	// Sector states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_ACK  = 2'd2;

	logic [1:0] state;
	logic       cart_active_q;
	logic       bk_ena;
	logic       bk_loading;
	logic       load_req, save_req;
	logic       load_req_q, save_req_q;
	logic       sd_ack_q;
	logic       load_start, save_start;
	logic       ack_rise, ack_fall;

	assign load_req = bk_load && bk_ena;
	// Autosave fires once the menu opens with unsaved writes
	assign save_req = (bk_save || (autosave && bk_pending && osd_open)) && bk_ena;

	// Download end also loads the save, if one exists
	assign load_start = (load_req && !load_req_q) ||
		(cart_active_q && !cart_active && img_size_nz && bk_ena);
	assign save_start = save_req && !save_req_q;

	assign ack_rise = sd_ack && !sd_ack_q;
	assign ack_fall = !sd_ack && sd_ack_q;

	assign bk_busy    = (state != ST_IDLE);
	assign core_reset = RESET || cart_active || bk_loading;

	//============================================================
	// Enable and pending flag
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			bk_ena        <= 1'b0;
			bk_pending    <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q)
				bk_ena <= 1'b0;
			// Save image is mounted before the download ends
			if (cart_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	//============================================================
	// Sector transfer FSM
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= ST_IDLE;
			load_req_q <= 1'b0;
			save_req_q <= 1'b0;
			sd_ack_q   <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			load_req_q <= load_req;
			save_req_q <= save_req;
			sd_ack_q   <= sd_ack;
			case (state)
				ST_IDLE: begin
					if (load_start || save_start) begin
						state      <= ST_REQ;
						bk_loading <= load_start;
						sd_lba     <= '0;
						sd_rd      <= load_start;
						sd_wr      <= !load_start;
					end
				end
				ST_REQ: begin
					// Host took the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (ack_fall) begin
						if (&sd_lba) begin
							state      <= ST_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + BK_SECTOR_BITS'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
							state  <= ST_REQ;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_rd_wr_exclusive : assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

endmodule

// File: logic/cheat_code_loader.sv
//============================================================
// Gathers sixteen cheat bytes into one 128-bit code
//============================================================

`timescale 1ns/100ps

module cheat_code_loader import sms_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	download_if.sink    dl,
	output cheat_code_u code,
	output logic        code_valid
);

	logic       code_wr;
	logic [1:0] field_sel;
	logic [1:0] byte_sel;

	assign code_wr = dl.download && dl.wr && (dl.index == IDX_CHEAT);

	// Four bytes per field, low byte first
	assign field_sel = dl.addr[3:2];
	assign byte_sel  = dl.addr[1:0];

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			code.lanes[field_sel][byte_sel] <= dl.data;
	end

	//============================================================
	// Valid pulse after the last byte of a code
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (dl.addr[3:0] == 4'hf);
	end

	// Consumers latch the code on valid, so it must be a single pulse
	a_valid_single : assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid held longer than one cycle");

endmodule

// File: logic/cart_loader.sv
//============================================================
// Cartridge download into ROM, size mask, Game Gear flag
// and masking of CPU ROM reads
//============================================================

`timescale 1ns/100ps

module cart_loader import sms_pkg::*; #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic           clk_sys,
	input  logic           RESET,
	download_if.sink       dl,
	input  logic           rom_wr_ack,
	input  rom_addr_t      cpu_rom_addr,
	output logic           dl_wait,
	output logic           rom_wr_req,
	output rom_addr_t      rom_wr_addr,
	output byte_t          rom_wr_data,
	output logic           cart_active,
	output logic           is_gg,
	output rom_addr_t      rom_rd_addr
);

	logic                  cart_active_q;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic [ROM_ADDR_W-1:0] cart_mask;
	logic                  cart_wr;

	// Cheat and system-mode downloads never reach the ROM
	assign cart_active = dl.download && (dl.index != IDX_CHEAT) &&
		(dl.index != IDX_SYSMODE) && (dl.index != IDX_DIPSW);

	assign cart_wr = dl.wr && cart_active;

	//============================================================
	// Toggle write handshake
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			dl_wait       <= 1'b0;
			rom_wr_req    <= 1'b0;
			wr_addr       <= '0;
			is_gg         <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_wr) begin
				dl_wait    <= 1'b1;
				rom_wr_req <= ~rom_wr_req;
				is_gg      <= (dl.index == IDX_GG);
			end else if (dl_wait && (rom_wr_req == rom_wr_ack)) begin
				// Memory caught up with the request
				dl_wait <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
			end
			// New image restarts at the bottom of ROM
			if (cart_active && !cart_active_q)
				wr_addr <= '0;
		end
	end

	//============================================================
	// Write data and size mask
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_wr_data <= dl.data;
			if (dl.addr == '0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | dl.addr[ROM_ADDR_W-1:0];
		end
	end

	assign rom_wr_addr = rom_addr_t'(wr_addr);

	// Mirror small images across the CPU window
	assign rom_rd_addr = cpu_rom_addr & rom_addr_t'(cart_mask);

	// Host must wait for the memory before the next byte
	a_no_wr_while_wait : assert property (@(posedge clk_sys) disable iff (RESET)
		dl.wr |-> !dl_wait)
		else $error("download strobe while dl_wait is high");

endmodule

// File: logic/ce_divider.sv
//============================================================
// Divide-by-30 clock-enable generator for CPU, VDP,
// pixel and sprite timing
//============================================================

`timescale 1ns/100ps

module ce_divider import sms_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	// VDP runs at one fifth, tracked by its own counter
	localparam logic [2:0] VDP_LAST = 3'd4;

	logic [4:0] phase;
	logic [2:0] vdp_phase;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			phase     <= '0;
			vdp_phase <= '0;
			ce_cpu    <= 1'b0;
			ce_vdp    <= 1'b0;
			ce_pix    <= 1'b0;
			ce_sp     <= 1'b0;
		end else begin
			phase     <= (phase == CE_PERIOD - 5'd1) ? 5'd0 : phase + 5'd1;
			vdp_phase <= (vdp_phase == VDP_LAST) ? 3'd0 : vdp_phase + 3'd1;

			// Sprite enable toggles every cycle
			ce_sp  <= phase[0];
			ce_vdp <= (vdp_phase == VDP_LAST);
			ce_pix <= (phase == CE_PIX_PH_A) || (phase == CE_PIX_PH_B) ||
				(phase == CE_PIX_PH_C);
			ce_cpu <= (phase == CE_CPU_PH_A) || (phase == CE_CPU_PH_B);
		end
	end

	// CPU phases sit on VDP slots, the Z80 bus timing relies on it
	a_cpu_on_vdp : assert property (@(posedge clk_sys) disable iff (RESET)
		ce_cpu |-> ce_vdp)
		else $error("ce_cpu high without ce_vdp");

endmodule

// File: logic/download_if.sv
//============================================================
// Host download bus bundle with its sink view
//============================================================

`timescale 1ns/100ps

interface download_if import sms_pkg::*; (
	input logic clk_sys
);

	logic     download;
	logic     wr;
	dl_addr_t addr;
	byte_t    data;
	byte_t    index;

	modport sink (
		input download,
		input wr,
		input addr,
		input data,
		input index
	);

	// Index selects the image type and must hold for a whole download
	a_index_stable : assert property (@(posedge clk_sys)
		(download && $past(download)) |-> $stable(index))
		else $error("download index changed during a download");

endinterface

// File: logic/sms_pkg.sv
//============================================================
// Shared widths, download index codes, divider phases
// and the cheat-code word with its byte and field views
//============================================================

package sms_pkg;

	// Basic widths
	typedef logic [24:0] dl_addr_t;
	typedef logic [21:0] rom_addr_t;
	typedef logic [7:0]  byte_t;

	//============================================================
	// Host download index codes
	//============================================================
	localparam byte_t IDX_SMS     = 8'd1;
	localparam byte_t IDX_GG      = 8'd2;
	localparam byte_t IDX_SYSMODE = 8'd4;
	localparam byte_t IDX_DIPSW   = 8'd254;
	localparam byte_t IDX_CHEAT   = 8'hff;

	//============================================================
	// Clock-enable divider
	//============================================================
	localparam logic [4:0] CE_PERIOD   = 5'd30;
	localparam logic [4:0] CE_CPU_PH_A = 5'd9;
	localparam logic [4:0] CE_CPU_PH_B = 5'd24;
	localparam logic [4:0] CE_PIX_PH_A = 5'd9;
	localparam logic [4:0] CE_PIX_PH_B = 5'd19;
	localparam logic [4:0] CE_PIX_PH_C = 5'd29;

	// Cheat code fields, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Outer lane index picks the field (0 is flags), inner index the byte, 0 lowest
	typedef union packed {
		byte_t [0:3][3:0] lanes;
		cheat_fields_t    fields;
	} cheat_code_u;

endpackage
